// File: project.f
+incdir+src
src/rvc_pkg.sv
src/rvc_quadrant0_expander.sv
src/rvc_quadrant1_expander.sv
src/rvc_quadrant2_expander.sv
src/rvc_decode_stage.sv
verification/tb_rvc_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module tb_rvc_decode_stage -f project.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// File: src/rvc_decode_stage.sv
`include "rvc_defines.svh"

module rvc_decode_stage
    import rvc_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_valid,
    input  instr_t i_instr,
    output logic   o_valid,
    output instr_t o_instr,
    output logic   o_is_compressed,
    output logic   o_illegal
);

    cinstr_t half;
    instr_t  q0_instr;
    instr_t  q1_instr;
    instr_t  q2_instr;
    logic    q0_illegal;
    logic    q1_illegal;
    logic    q2_illegal;
    instr_t  sel_instr;
    logic    sel_illegal;
    logic    is_compressed;
    instr_t  next_instr;

    assign half = i_instr[15:0];

    rvc_quadrant0_expander u_q0 (
        .i_half    (half),
        .o_instr   (q0_instr),
        .o_illegal (q0_illegal)
    );

    rvc_quadrant1_expander u_q1 (
        .i_half    (half),
        .o_instr   (q1_instr),
        .o_illegal (q1_illegal)
    );

    rvc_quadrant2_expander u_q2 (
        .i_half    (half),
        .o_instr   (q2_instr),
        .o_illegal (q2_illegal)
    );

    always_comb begin
        sel_instr     = i_instr;
        sel_illegal   = 1'b0;
        is_compressed = 1'b1;
        case (i_instr[1:0])
            `RVC_Q0: begin
                sel_instr   = q0_instr;
                sel_illegal = q0_illegal;
            end
            `RVC_Q1: begin
                sel_instr   = q1_instr;
                sel_illegal = q1_illegal;
            end
            `RVC_Q2: begin
                sel_instr   = q2_instr;
                sel_illegal = q2_illegal;
            end
            default: is_compressed = 1'b0; // Full 32-bit word
        endcase
    end

    // Illegal and uncompressed words pass through as fetched
    assign next_instr = (is_compressed && !sel_illegal) ? sel_instr : i_instr;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid         <= 1'b0;
            o_instr         <= '0;
            o_is_compressed <= 1'b0;
            o_illegal       <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin // Hold data over idle cycles
                o_instr         <= next_instr;
                o_is_compressed <= is_compressed;
                o_illegal       <= sel_illegal;
            end
        end
    end

    a_valid_after_reset : assert property (@(posedge i_clk) i_rst |=> !o_valid);

    a_illegal_is_compressed : assert property (
        @(posedge i_clk) disable iff (i_rst) o_illegal |-> o_is_compressed
    );

endmodule

// File: src/rvc_defines.svh
`ifndef RVC_DEFINES_SVH
`define RVC_DEFINES_SVH

// RV32I major opcodes
`define RVC_OPC_OP_IMM  7'b0010011
`define RVC_OPC_OP      7'b0110011
`define RVC_OPC_LOAD    7'b0000011
`define RVC_OPC_STORE   7'b0100011
`define RVC_OPC_BRANCH  7'b1100011
`define RVC_OPC_JAL     7'b1101111
`define RVC_OPC_JALR    7'b1100111
`define RVC_OPC_LUI     7'b0110111

// RV32I funct3 codes used by the expansions
`define RVC_F3_ADD      3'b000
`define RVC_F3_SLL      3'b001
`define RVC_F3_WORD     3'b010 // lw / sw
`define RVC_F3_XOR      3'b100
`define RVC_F3_SR       3'b101 // srli / srai
`define RVC_F3_OR       3'b110
`define RVC_F3_AND      3'b111
`define RVC_F3_BEQ      3'b000
`define RVC_F3_BNE      3'b001

`define RVC_EBREAK_WORD 32'h0010_0073

`define RVC_REG_ZERO    5'd0
`define RVC_REG_RA      5'd1
`define RVC_REG_SP      5'd2
`define RVC_CREG_BASE   2'b01 // x8..x15

`define RVC_Q0          2'b00
`define RVC_Q1          2'b01
`define RVC_Q2          2'b10

`endif

// File: src/rvc_pkg.sv
package rvc_pkg;

    // Full RV32I instruction word
    typedef logic [31:0] instr_t;

    // Compressed halfword
    typedef logic [15:0] cinstr_t;

    // Register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // Compressed register index, maps to x8..x15
    typedef logic [2:0] creg_idx_t;

    // Compressed major function, bits [15:13]
    typedef logic [2:0] funct3_t;

endpackage

// File: src/rvc_quadrant0_expander.sv
`include "rvc_defines.svh"

module rvc_quadrant0_expander
    import rvc_pkg::*;
(
    input  cinstr_t i_half,
    output instr_t  o_instr,
    output logic    o_illegal
);

    funct3_t     funct3;
    creg_idx_t   rs1_c;
    creg_idx_t   rd_c;
    reg_idx_t    rs1_p;
    reg_idx_t    rd_p;
    logic [11:0] imm_4spn;
    logic [11:0] imm_word;

    assign funct3   = i_half[15:13];
    assign rs1_c    = i_half[9:7];
    assign rd_c     = i_half[4:2];  // rd' for loads, rs2' for stores
    assign rs1_p    = {`RVC_CREG_BASE, rs1_c};
    assign rd_p     = {`RVC_CREG_BASE, rd_c};
    assign imm_4spn = {2'b00, i_half[10:7], i_half[12:11], i_half[5], i_half[6], 2'b00};
    assign imm_word = {5'b0, i_half[5], i_half[12:10], i_half[6], 2'b00};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (funct3)
            3'b000: begin // C.ADDI4SPN
                o_instr   = {imm_4spn, `RVC_REG_SP, `RVC_F3_ADD, rd_p, `RVC_OPC_OP_IMM};
                o_illegal = (i_half[12:5] == 8'b0);
            end
            3'b010: begin // C.LW
                o_instr = {imm_word, rs1_p, `RVC_F3_WORD, rd_p, `RVC_OPC_LOAD};
            end
            3'b110: begin // C.SW
                o_instr = {imm_word[11:5], rd_p, rs1_p, `RVC_F3_WORD, imm_word[4:0],
                           `RVC_OPC_STORE};
            end
            default: o_illegal = 1'b1; // FP and RV64 forms
        endcase

        assert (o_illegal || o_instr[1:0] == 2'b11);
    end

endmodule

// File: src/rvc_quadrant1_expander.sv
`include "rvc_defines.svh"

module rvc_quadrant1_expander
    import rvc_pkg::*;
(
    input  cinstr_t i_half,
    output instr_t  o_instr,
    output logic    o_illegal
);

    funct3_t     funct3;
    reg_idx_t    rd;
    creg_idx_t   rd_c;
    creg_idx_t   rs2_c;
    reg_idx_t    rd_p;
    reg_idx_t    rs2_p;
    logic [5:0]  imm6;
    logic [11:0] imm_i;
    logic [11:0] imm_16sp;
    logic        sgn;

    assign funct3   = i_half[15:13];
    assign rd       = i_half[11:7];
    assign rd_c     = i_half[9:7];
    assign rs2_c    = i_half[4:2];
    assign rd_p     = {`RVC_CREG_BASE, rd_c};
    assign rs2_p    = {`RVC_CREG_BASE, rs2_c};
    assign sgn      = i_half[12];
    assign imm6     = {sgn, i_half[6:2]};
    assign imm_i    = {{6{sgn}}, imm6};
    assign imm_16sp = {{3{sgn}}, i_half[4:3], i_half[5], i_half[2], i_half[6], 4'b0000};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (funct3)
            3'b000: begin // C.ADDI, C.NOP
                o_instr = {imm_i, rd, `RVC_F3_ADD, rd, `RVC_OPC_OP_IMM};
            end
            3'b010: begin // C.LI
                o_instr = {imm_i, `RVC_REG_ZERO, `RVC_F3_ADD, rd, `RVC_OPC_OP_IMM};
            end
            3'b011: begin
                if (rd == `RVC_REG_SP) begin // C.ADDI16SP
                    o_instr   = {imm_16sp, `RVC_REG_SP, `RVC_F3_ADD, `RVC_REG_SP,
                                 `RVC_OPC_OP_IMM};
                    o_illegal = (imm6 == 6'b0);
                end else begin // C.LUI
                    o_instr   = {{15{sgn}}, i_half[6:2], rd, `RVC_OPC_LUI};
                    o_illegal = (imm6 == 6'b0) || (rd == `RVC_REG_ZERO);
                end
            end
            3'b100: begin
                case (i_half[11:10])
                    2'b00: begin // C.SRLI
                        o_instr   = {7'b0000000, i_half[6:2], rd_p, `RVC_F3_SR, rd_p,
                                     `RVC_OPC_OP_IMM};
                        o_illegal = sgn; // shamt[5] not allowed on RV32
                    end
                    2'b01: begin // C.SRAI
                        o_instr   = {7'b0100000, i_half[6:2], rd_p, `RVC_F3_SR, rd_p,
                                     `RVC_OPC_OP_IMM};
                        o_illegal = sgn;
                    end
                    2'b10: begin // C.ANDI
                        o_instr = {imm_i, rd_p, `RVC_F3_AND, rd_p, `RVC_OPC_OP_IMM};
                    end
                    default: begin
                        if (sgn) begin
                            o_illegal = 1'b1; // SUBW, ADDW and reserved
                        end else begin
                            case (i_half[6:5])
                                2'b00: o_instr = {7'b0100000, rs2_p, rd_p, `RVC_F3_ADD, rd_p,
                                                  `RVC_OPC_OP}; // C.SUB
                                2'b01: o_instr = {7'b0000000, rs2_p, rd_p, `RVC_F3_XOR, rd_p,
                                                  `RVC_OPC_OP};
                                2'b10: o_instr = {7'b0000000, rs2_p, rd_p, `RVC_F3_OR, rd_p,
                                                  `RVC_OPC_OP};
                                default: o_instr = {7'b0000000, rs2_p, rd_p, `RVC_F3_AND,
                                                    rd_p, `RVC_OPC_OP};
                            endcase
                        end
                    end
                endcase
            end
            3'b101: begin // C.J
                o_instr = {sgn, i_half[8], i_half[10:9], i_half[6], i_half[7], i_half[2],
                           i_half[11], i_half[5:3], sgn, {8{sgn}}, `RVC_REG_ZERO,
                           `RVC_OPC_JAL};
            end
            3'b110: begin // C.BEQZ
                o_instr = {{4{sgn}}, i_half[6:5], i_half[2], `RVC_REG_ZERO, rd_p, `RVC_F3_BEQ,
                           i_half[11:10], i_half[4:3], sgn, `RVC_OPC_BRANCH};
            end
            3'b111: begin // C.BNEZ
                o_instr = {{4{sgn}}, i_half[6:5], i_half[2], `RVC_REG_ZERO, rd_p, `RVC_F3_BNE,
                           i_half[11:10], i_half[4:3], sgn, `RVC_OPC_BRANCH};
            end
            default: o_illegal = 1'b1; // 001, C.JAL / C.ADDIW not supported
        endcase

        assert (o_illegal || o_instr[1:0] == 2'b11);
    end

endmodule

// File: src/rvc_quadrant2_expander.sv
`include "rvc_defines.svh"

module rvc_quadrant2_expander
    import rvc_pkg::*;
(
    input  cinstr_t i_half,
    output instr_t  o_instr,
    output logic    o_illegal
);

    funct3_t     funct3;
    reg_idx_t    rd;
    reg_idx_t    rs2;
    logic [11:0] imm_lwsp;
    logic [11:0] imm_swsp;

    assign funct3   = i_half[15:13];
    assign rd       = i_half[11:7];  // also rs1 for JR / JALR
    assign rs2      = i_half[6:2];
    assign imm_lwsp = {4'b0, i_half[3:2], i_half[12], i_half[6:4], 2'b00};
    assign imm_swsp = {4'b0, i_half[8:7], i_half[12:9], 2'b00};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (funct3)
            3'b000: begin // C.SLLI
                o_instr   = {7'b0000000, rs2, rd, `RVC_F3_SLL, rd, `RVC_OPC_OP_IMM};
                o_illegal = i_half[12];
            end
            3'b010: begin // C.LWSP
                o_instr   = {imm_lwsp, `RVC_REG_SP, `RVC_F3_WORD, rd, `RVC_OPC_LOAD};
                o_illegal = (rd == `RVC_REG_ZERO);
            end
            3'b100: begin
                if (!i_half[12]) begin
                    if (rs2 == `RVC_REG_ZERO) begin // C.JR
                        o_instr   = {12'b0, rd, `RVC_F3_ADD, `RVC_REG_ZERO, `RVC_OPC_JALR};
                        o_illegal = (rd == `RVC_REG_ZERO);
                    end else begin // C.MV
                        o_instr = {7'b0000000, rs2, `RVC_REG_ZERO, `RVC_F3_ADD, rd,
                                   `RVC_OPC_OP};
                    end
                end else if (rs2 == `RVC_REG_ZERO) begin
                    if (rd == `RVC_REG_ZERO) begin
                        o_instr = `RVC_EBREAK_WORD;
                    end else begin // C.JALR
                        o_instr = {12'b0, rd, `RVC_F3_ADD, `RVC_REG_RA, `RVC_OPC_JALR};
                    end
                end else begin // C.ADD
                    o_instr = {7'b0000000, rs2, rd, `RVC_F3_ADD, rd, `RVC_OPC_OP};
                end
            end
            3'b110: begin // C.SWSP
                o_instr = {imm_swsp[11:5], rs2, `RVC_REG_SP, `RVC_F3_WORD, imm_swsp[4:0],
                           `RVC_OPC_STORE};
            end
            default: o_illegal = 1'b1; // FP and RV64 stack forms
        endcase

        assert (o_illegal || o_instr[1:0] == 2'b11);
    end

endmodule

// File: verification/rvc_golden.hex
// Columns: input word (8 hex), expected instruction (8 hex), flags (2 hex)
// Flags bit 1 is compressed, bit 0 is illegal; expansions follow the RVC specification
000013541A41069302 // c.addi4spn x13, sp, 420
000045240485248302 // c.lw x9, 72(x10)
0000C02C04B4202302 // c.sw x11, 64(x8)
ABCD0004ABCD000403 // c.addi4spn zero immediate
000061080000610803 // c.ld
0000E1080000E10803 // c.sd
000000010000001302 // c.nop
000012F5FFD2829302 // c.addi x5, -3
00005081FE00009302 // c.li x1, -32
0000617D1F01011302 // c.addi16sp 496
00007781FFFE07B702 // c.lui x15, 0xfffe0
0000800D0034541302 // c.srli x8, 3
000084FD41F4D49302 // c.srai x9, 31
0000997DFFF5751302 // c.andi x10, -1
00008C054094043302 // c.sub x8, x9
00008E3500D6463302 // c.xor x12, x13
00008F5D00F7673302 // c.or x14, x15
00008FE10087F7B302 // c.and x15, x8
0000A0450A00006F02 // c.j +160
0000B001801FF06F02 // c.j -2048
0000C0110004026302 // c.beqz x8, +4
0000F081F00490E302 // c.bnez x9, -256
0000E7CD0A07956302 // c.bnez x15, +170
000061010000610103 // c.addi16sp zero immediate
000061810000618103 // c.lui zero immediate
000060050000600503 // c.lui to x0
000090010000900103 // c.srli shamt[5] set
000022850000228503 // c.addiw
00009C0500009C0503 // c.subw
00009C2500009C2503 // c.addw
000003960053939302 // c.slli x7, 5
00004F9604412F8302 // c.lwsp x31, 68
0000C3220881222302 // c.swsp x8, 132
000080820000806702 // c.jr x1
0000852E00B0053302 // c.mv x10, x11
000090020010007302 // c.ebreak
00009282000280E702 // c.jalr x5
0000963600D6063302 // c.add x12, x13
000013820000138203 // c.slli shamt[5] set
000040120000401203 // c.lwsp to x0
000080020000800203 // c.jr x0
000020820000208203 // c.fldsp
000060820000608203 // c.ldsp
0000E0020000E00203 // c.sdsp
00A5053300A5053300 // add x10, x10, x10 uncompressed

// File: verification/tb_rvc_decode_stage.sv
module tb_rvc_decode_stage
    import rvc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VEC     = 45;
    localparam int NUM_RAND    = 32;
    localparam int RST_CYCLES  = 16;
    // Each random word may be followed by one idle cycle
    localparam int CYCLE_LIMIT = RST_CYCLES + NUM_VEC + 2 * NUM_RAND + 20;

    logic        clk;
    logic        rst;
    logic        in_valid;
    instr_t      in_instr;
    logic        out_valid;
    instr_t      out_instr;
    logic        out_compressed;
    logic        out_illegal;

    logic [71:0] golden [0:NUM_VEC-1];
    logic [33:0] exp_q [$];  // {instr, compressed, illegal}
    instr_t      last_instr;
    logic        last_compressed;
    logic        last_illegal;
    logic        valid_d;
    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;
    int          cycle_count;

    rvc_decode_stage DUT (
        .i_clk           (clk),
        .i_rst           (rst),
        .i_valid         (in_valid),
        .i_instr         (in_instr),
        .o_valid         (out_valid),
        .o_instr         (out_instr),
        .o_is_compressed (out_compressed),
        .o_illegal       (out_illegal)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic send_word(input instr_t word, input logic [33:0] expected);
        @(negedge clk);
        in_valid = 1'b1;
        in_instr = word;
        exp_q.push_back(expected);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        in_instr = ~in_instr; // Must not reach the outputs
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // One cycle of delay from i_valid to o_valid
    always @(posedge clk) begin
        valid_d <= rst ? 1'b0 : in_valid;
    end

    always @(negedge clk) begin : monitor
        logic [33:0] entry;
        if (rst) begin
            last_instr      = '0;
            last_compressed = 1'b0;
            last_illegal    = 1'b0;
            check_value("o_valid", {31'd0, out_valid}, 32'd0);
        end else begin
            check_value("o_valid", {31'd0, out_valid}, {31'd0, valid_d});
            if (out_valid && exp_q.size() == 0) begin
                error_count++;
                $display("ERROR at %0t: output valid with no word outstanding", $time);
            end else if (out_valid) begin
                entry = exp_q.pop_front();
                {last_instr, last_compressed, last_illegal} = entry;
            end
        end
        check_value("o_instr", out_instr, last_instr); // Held values when idle
        check_value("o_is_compressed", {31'd0, out_compressed}, {31'd0, last_compressed});
        check_value("o_illegal", {31'd0, out_illegal}, {31'd0, last_illegal});
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        in_valid        = 1'b0;
        in_instr        = '0;
        error_count     = 0;
        check_count     = 0;
        last_instr      = '0;
        last_compressed = 1'b0;
        last_illegal    = 1'b0;
        lcg_state       = 32'h2c0f_46c0;
        for (int i = 0; i < NUM_VEC; i++) begin
            golden[i] = 'x;
        end
        $readmemh("verification/rvc_golden.hex", golden);
        if ($isunknown(golden[NUM_VEC-1])) begin
            error_count++;
            $display("ERROR: golden file is missing or holds fewer than %0d vectors", NUM_VEC);
        end

        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_VEC; i++) begin // Back to back
            send_word(golden[i][71:40], {golden[i][39:8], golden[i][1:0]});
        end

        for (int i = 0; i < NUM_RAND; i++) begin
            lcg_state = lcg_next(lcg_state);
            send_word({lcg_state[31:2], 2'b11}, {lcg_state[31:2], 2'b11, 2'b00});
            if (lcg_state[20]) begin
                idle_cycle();
            end
        end

        idle_cycle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) idle_cycle();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
